/* source/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    localparam int ARCH_W     = 5;  // Architectural register number
    localparam int PHYS_W_MAX = 7;  // Room for 128 physical registers
    localparam int ROB_W_MAX  = 5;  // Room for 32 ROB slots

    // Index width for n items, at least one bit
    function automatic int idx_w(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    typedef struct packed {
        logic [ARCH_W-1:0] rd_arch;  // Destination register
        logic              uses_rd;  // Writes a destination
    } decoded_bundle_t;

    typedef struct packed {
        logic [ARCH_W-1:0]     rd_arch;
        logic                  uses_rd;
        logic [PHYS_W_MAX-1:0] pd_new;  // Register given by rename
        logic [PHYS_W_MAX-1:0] pd_old;  // Mapping it replaced
    } rob_entry_t;

    typedef struct packed {
        logic [ROB_W_MAX-1:0] rob_idx;  // Slot of the finished instruction
    } fu_wb_t;

endpackage

`default_nettype wire

/* source/free_list.sv */
`timescale 1ns/1ps
`default_nettype none

module free_list #(
    parameter int ARCH_REGS = 32,
    parameter int PHYS_REGS = 40,
    localparam int PHYS_W   = rename_pkg::idx_w(PHYS_REGS)
) (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_pop,     // Rename takes the head
    output logic              o_empty,
    output logic [PHYS_W-1:0] o_pop_pd,  // Next register handed out
    input  logic              i_push,    // Commit or recovery return
    input  logic [PHYS_W-1:0] i_push_pd
);
    import rename_pkg::*;

    localparam int DEPTH = PHYS_REGS - ARCH_REGS;  // Spare registers only
    localparam int PTR_W = idx_w(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [PHYS_W-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0]  head_q;
    logic [PTR_W-1:0]  tail_q;
    logic [CNT_W-1:0]  count_q;
    logic              full;

    function automatic logic [PTR_W-1:0] wrap_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_empty  = (count_q == '0);
    assign full     = (count_q == CNT_W'(DEPTH));
    assign o_pop_pd = mem_q[head_q];  // Head always visible

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;  // Meets head, list starts full
            count_q <= CNT_W'(DEPTH);
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= PHYS_W'(ARCH_REGS + i);  // Ascending spares
            end
        end else begin
            if (i_pop) begin
                head_q <= wrap_inc(head_q);
            end
            if (i_push) begin
                mem_q[tail_q] <= i_push_pd;
                tail_q        <= wrap_inc(tail_q);
            end
            count_q <= count_q + CNT_W'(i_push) - CNT_W'(i_pop);
        end
    end

    initial assert (PHYS_W <= PHYS_W_MAX) else $fatal(1, "free_list: PHYS_W too wide");

    a_pop_not_empty: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_pop |-> !o_empty);
    a_push_not_full: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_push |-> !full);  // Never more spares than exist

endmodule

`default_nettype wire

/* source/rename_table.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_table #(
    parameter int ARCH_REGS = 32,
    parameter int PHYS_REGS = 40,
    localparam int PHYS_W   = rename_pkg::idx_w(PHYS_REGS)
) (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic [rename_pkg::ARCH_W-1:0] i_rs1_arch,
    input  logic [rename_pkg::ARCH_W-1:0] i_rs2_arch,
    input  logic [rename_pkg::ARCH_W-1:0] i_rd_arch,
    output logic [PHYS_W-1:0]             o_rs1_phys,
    output logic [PHYS_W-1:0]             o_rs2_phys,
    output logic [PHYS_W-1:0]             o_rd_phys,   // Mapping about to be replaced
    input  logic                          i_rename_we,
    input  logic [rename_pkg::ARCH_W-1:0] i_rename_rd_arch,
    input  logic [PHYS_W-1:0]             i_rename_pd,
    input  logic                          i_recover_we,
    input  logic [rename_pkg::ARCH_W-1:0] i_recover_rd_arch,
    input  logic [PHYS_W-1:0]             i_recover_pd
);
    import rename_pkg::*;

    logic [PHYS_W-1:0] map_q [ARCH_REGS];

    // Reads see the table before any same-cycle write
    assign o_rs1_phys = map_q[i_rs1_arch];
    assign o_rs2_phys = map_q[i_rs2_arch];
    assign o_rd_phys  = map_q[i_rd_arch];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= PHYS_W'(i);  // Identity
            end
        end else if (i_recover_we && i_recover_rd_arch != '0) begin
            map_q[i_recover_rd_arch] <= i_recover_pd;  // Undo squashed rename
        end else if (i_rename_we && i_rename_rd_arch != '0) begin
            map_q[i_rename_rd_arch] <= i_rename_pd;  // r0 stays fixed
        end
    end

    initial assert (PHYS_W <= PHYS_W_MAX && ARCH_REGS <= 2 ** ARCH_W)
        else $fatal(1, "rename_table: register widths out of range");

    // Walk blocks allocation, so the two writers never meet
    a_one_writer: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_rename_we && i_recover_we));

endmodule

`default_nettype wire

/* source/rob_slot.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_slot #(
    parameter int ROB_SIZE = 8,
    parameter int SLOT_IDX = 0,
    localparam int ROB_W   = rename_pkg::idx_w(ROB_SIZE)
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_write,   // Allocation at tail
    input  rename_pkg::rob_entry_t i_entry,
    input  logic                   i_clear,   // Commit or squash
    input  logic                   i_wb_valid,
    input  logic [ROB_W-1:0]       i_wb_idx,
    output rename_pkg::rob_entry_t o_entry,
    output logic                   o_valid,
    output logic                   o_done
);
    import rename_pkg::*;

    logic wb_hit;

    assign wb_hit = i_wb_valid && (i_wb_idx == ROB_W'(SLOT_IDX));  // Own index only

    always_ff @(posedge clk) begin
        if (i_write) begin
            o_entry <= i_entry;  // Payload
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_done  <= 1'b0;
        end else if (i_write) begin
            o_valid <= 1'b1;
            o_done  <= 1'b0;  // New entry not finished yet
        end else begin
            if (i_clear) begin
                o_valid <= 1'b0;
            end
            if (wb_hit) begin
                o_done <= 1'b1;
            end
        end
    end

    initial assert (ROB_W <= ROB_W_MAX) else $fatal(1, "rob_slot: ROB_W too wide");

    // Head and tail share a slot only when full or empty
    a_write_xor_clear: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_write && i_clear));

endmodule

`default_nettype wire

/* source/rob_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_ctrl #(
    parameter int ROB_SIZE  = 8,
    parameter int PHYS_REGS = 40,
    localparam int ROB_W    = rename_pkg::idx_w(ROB_SIZE),
    localparam int PHYS_W   = rename_pkg::idx_w(PHYS_REGS)
) (
    input  logic                                  clk,
    input  logic                                  i_rst_n,
    input  logic                                  i_alloc_valid,
    input  rename_pkg::decoded_bundle_t           i_alloc_bundle,
    input  logic                                  i_fl_empty,
    input  logic [PHYS_W-1:0]                     i_fl_pd,
    input  logic [PHYS_W-1:0]                     i_rat_rd_phys,
    output logic                                  o_alloc_ready,
    output logic [ROB_W-1:0]                      o_alloc_rob_idx,
    output logic                                  o_fl_pop,
    output logic                                  o_fl_push,
    output logic [PHYS_W-1:0]                     o_fl_push_pd,
    output logic [ROB_SIZE-1:0]                   o_slot_write,
    output rename_pkg::rob_entry_t                o_slot_entry,
    output logic [ROB_SIZE-1:0]                   o_slot_clear,
    input  rename_pkg::rob_entry_t [ROB_SIZE-1:0] i_slot_entries,
    input  logic [ROB_SIZE-1:0]                   i_slot_valid,
    input  logic [ROB_SIZE-1:0]                   i_slot_done,
    output logic                                  o_rat_rename_we,
    output logic                                  o_rat_recover_we,
    output logic                                  o_commit_valid,
    input  logic                                  i_commit_ready,
    output rename_pkg::rob_entry_t                o_commit_entry,
    output logic [ROB_W-1:0]                      o_commit_rob_idx,
    input  logic                                  i_flush_valid,
    input  logic [ROB_W-1:0]                      i_flush_rob_idx,
    output logic                                  o_recover_valid,
    output logic [ROB_W-1:0]                      o_recover_rob_idx,
    output rename_pkg::rob_entry_t                o_recover_entry
);
    import rename_pkg::*;

    localparam int CNT_W = $clog2(ROB_SIZE + 1);

    logic [ROB_W-1:0] head_q;     // Oldest entry
    logic [ROB_W-1:0] tail_q;     // Next free slot
    logic [ROB_W-1:0] stop_q;     // Walk ends when tail lands here
    logic [CNT_W-1:0] count_q;
    logic             recover_q;
    logic [ROB_W-1:0] walk_idx;   // Youngest live entry
    logic             alloc_fire;
    logic             commit_fire;
    logic             flush_start;

    function automatic logic [ROB_W-1:0] inc_idx(input logic [ROB_W-1:0] idx);
        return (idx == ROB_W'(ROB_SIZE - 1)) ? '0 : idx + 1'b1;
    endfunction

    function automatic logic [ROB_W-1:0] dec_idx(input logic [ROB_W-1:0] idx);
        return (idx == '0) ? ROB_W'(ROB_SIZE - 1) : idx - 1'b1;
    endfunction

    assign walk_idx    = dec_idx(tail_q);
    assign flush_start = i_flush_valid && !recover_q;  // Flush mid-walk is dropped

    // Empty free list blocks every bundle, rd or not
    assign o_alloc_ready   = (count_q != CNT_W'(ROB_SIZE)) && !i_fl_empty
                             && !recover_q && !i_flush_valid;
    assign alloc_fire      = i_alloc_valid && o_alloc_ready;
    assign o_alloc_rob_idx = tail_q;
    assign o_fl_pop        = alloc_fire && i_alloc_bundle.uses_rd;
    assign o_rat_rename_we = o_fl_pop;

    always_comb begin
        o_slot_entry.rd_arch = i_alloc_bundle.rd_arch;
        o_slot_entry.uses_rd = i_alloc_bundle.uses_rd;
        o_slot_entry.pd_new  = i_alloc_bundle.uses_rd ? PHYS_W_MAX'(i_fl_pd) : '0;
        o_slot_entry.pd_old  = i_alloc_bundle.uses_rd ? PHYS_W_MAX'(i_rat_rd_phys) : '0;
    end

    assign o_commit_entry   = i_slot_entries[head_q];
    assign o_commit_rob_idx = head_q;
    assign o_commit_valid   = i_slot_valid[head_q] && i_slot_done[head_q] && !recover_q;
    assign commit_fire      = o_commit_valid && i_commit_ready;

    assign o_recover_valid   = recover_q;
    assign o_recover_rob_idx = walk_idx;
    assign o_recover_entry   = i_slot_entries[walk_idx];
    assign o_rat_recover_we  = recover_q && o_recover_entry.uses_rd;  // Restore pd_old

    // Commit frees the replaced mapping, the walk frees the squashed one
    assign o_fl_push    = (commit_fire && o_commit_entry.uses_rd) || o_rat_recover_we;
    assign o_fl_push_pd = recover_q ? PHYS_W'(o_recover_entry.pd_new)
                                    : PHYS_W'(o_commit_entry.pd_old);

    assign o_slot_write = alloc_fire ? (ROB_SIZE'(1) << tail_q) : '0;
    assign o_slot_clear = (commit_fire ? (ROB_SIZE'(1) << head_q) : '0)
                        | (recover_q ? (ROB_SIZE'(1) << walk_idx) : '0);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            head_q    <= '0;
            tail_q    <= '0;
            stop_q    <= '0;
            count_q   <= '0;
            recover_q <= 1'b0;
        end else begin
            if (commit_fire) begin
                head_q <= inc_idx(head_q);
            end
            if (alloc_fire) begin
                tail_q <= inc_idx(tail_q);
            end else if (recover_q) begin
                tail_q <= walk_idx;  // Retract one per cycle
                if (walk_idx == stop_q) begin
                    recover_q <= 1'b0;
                end
            end
            if (flush_start) begin
                stop_q    <= inc_idx(i_flush_rob_idx);  // Flushed entry survives
                recover_q <= (tail_q != inc_idx(i_flush_rob_idx));  // No younger, no walk
            end
            count_q <= count_q + CNT_W'(alloc_fire) - CNT_W'(commit_fire) - CNT_W'(recover_q);
        end
    end

    initial assert (ROB_W <= ROB_W_MAX && PHYS_W <= PHYS_W_MAX)
        else $fatal(1, "rob_ctrl: ROB_W or PHYS_W too wide");

    a_no_flush_in_walk: assert property (@(posedge clk) disable iff (!i_rst_n)
        recover_q |-> !i_flush_valid);
    a_flush_live_entry: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_flush_valid |-> i_slot_valid[i_flush_rob_idx]);

endmodule

`default_nettype wire

/* source/commit_rename.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_rename #(
    parameter int ARCH_REGS = 32,
    parameter int PHYS_REGS = 40,
    parameter int ROB_SIZE  = 8,
    localparam int ROB_W    = rename_pkg::idx_w(ROB_SIZE),
    localparam int PHYS_W   = rename_pkg::idx_w(PHYS_REGS)
) (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic                          i_alloc_valid,
    output logic                          o_alloc_ready,
    input  rename_pkg::decoded_bundle_t   i_alloc_bundle,
    output logic [ROB_W-1:0]              o_alloc_rob_idx,
    input  logic [rename_pkg::ARCH_W-1:0] i_rs1_arch,
    input  logic [rename_pkg::ARCH_W-1:0] i_rs2_arch,
    output logic [PHYS_W-1:0]             o_rs1_phys,
    output logic [PHYS_W-1:0]             o_rs2_phys,
    input  logic                          i_wb_valid,
    input  rename_pkg::fu_wb_t            i_wb_pkt,
    output logic                          o_commit_valid,
    input  logic                          i_commit_ready,
    output rename_pkg::rob_entry_t        o_commit_entry,
    output logic [ROB_W-1:0]              o_commit_rob_idx,
    input  logic                          i_flush_valid,
    input  logic [ROB_W-1:0]              i_flush_rob_idx,
    output logic                          o_recover_valid,
    output logic [ROB_W-1:0]              o_recover_rob_idx,
    output rename_pkg::rob_entry_t        o_recover_entry
);
    import rename_pkg::*;

    logic                         fl_empty;
    logic [PHYS_W-1:0]            fl_pd;        // Free-list head
    logic                         fl_pop;
    logic                         fl_push;
    logic [PHYS_W-1:0]            fl_push_pd;
    logic [PHYS_W-1:0]            rat_rd_phys;  // Old mapping of rd
    logic                         rat_rename_we;
    logic                         rat_recover_we;
    logic [ROB_SIZE-1:0]          slot_write;
    logic [ROB_SIZE-1:0]          slot_clear;
    rob_entry_t                   slot_entry;
    rob_entry_t [ROB_SIZE-1:0]    slot_entries;
    logic [ROB_SIZE-1:0]          slot_valid;
    logic [ROB_SIZE-1:0]          slot_done;

    free_list #(
        .ARCH_REGS (ARCH_REGS),
        .PHYS_REGS (PHYS_REGS)
    ) u_free_list (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_pop     (fl_pop),
        .o_empty   (fl_empty),
        .o_pop_pd  (fl_pd),
        .i_push    (fl_push),
        .i_push_pd (fl_push_pd)
    );

    rename_table #(
        .ARCH_REGS (ARCH_REGS),
        .PHYS_REGS (PHYS_REGS)
    ) u_rename_table (
        .clk               (clk),
        .i_rst_n           (i_rst_n),
        .i_rs1_arch        (i_rs1_arch),
        .i_rs2_arch        (i_rs2_arch),
        .i_rd_arch         (i_alloc_bundle.rd_arch),
        .o_rs1_phys        (o_rs1_phys),
        .o_rs2_phys        (o_rs2_phys),
        .o_rd_phys         (rat_rd_phys),
        .i_rename_we       (rat_rename_we),
        .i_rename_rd_arch  (i_alloc_bundle.rd_arch),
        .i_rename_pd       (fl_pd),
        .i_recover_we      (rat_recover_we),
        .i_recover_rd_arch (o_recover_entry.rd_arch),
        .i_recover_pd      (PHYS_W'(o_recover_entry.pd_old))  // Walked entry's old map
    );

    rob_ctrl #(
        .ROB_SIZE  (ROB_SIZE),
        .PHYS_REGS (PHYS_REGS)
    ) u_rob_ctrl (
        .clk               (clk),
        .i_rst_n           (i_rst_n),
        .i_alloc_valid     (i_alloc_valid),
        .i_alloc_bundle    (i_alloc_bundle),
        .i_fl_empty        (fl_empty),
        .i_fl_pd           (fl_pd),
        .i_rat_rd_phys     (rat_rd_phys),
        .o_alloc_ready     (o_alloc_ready),
        .o_alloc_rob_idx   (o_alloc_rob_idx),
        .o_fl_pop          (fl_pop),
        .o_fl_push         (fl_push),
        .o_fl_push_pd      (fl_push_pd),
        .o_slot_write      (slot_write),
        .o_slot_entry      (slot_entry),
        .o_slot_clear      (slot_clear),
        .i_slot_entries    (slot_entries),
        .i_slot_valid      (slot_valid),
        .i_slot_done       (slot_done),
        .o_rat_rename_we   (rat_rename_we),
        .o_rat_recover_we  (rat_recover_we),
        .o_commit_valid    (o_commit_valid),
        .i_commit_ready    (i_commit_ready),
        .o_commit_entry    (o_commit_entry),
        .o_commit_rob_idx  (o_commit_rob_idx),
        .i_flush_valid     (i_flush_valid),
        .i_flush_rob_idx   (i_flush_rob_idx),
        .o_recover_valid   (o_recover_valid),
        .o_recover_rob_idx (o_recover_rob_idx),
        .o_recover_entry   (o_recover_entry)
    );

    for (genvar i = 0; i < ROB_SIZE; i++) begin : g_slot
        rob_slot #(
            .ROB_SIZE (ROB_SIZE),
            .SLOT_IDX (i)
        ) u_slot (
            .clk        (clk),
            .i_rst_n    (i_rst_n),
            .i_write    (slot_write[i]),
            .i_entry    (slot_entry),
            .i_clear    (slot_clear[i]),
            .i_wb_valid (i_wb_valid),
            .i_wb_idx   (ROB_W'(i_wb_pkt.rob_idx)),  // Each slot decodes its own hit
            .o_entry    (slot_entries[i]),
            .o_valid    (slot_valid[i]),
            .o_done     (slot_done[i])
        );
    end

endmodule

`default_nettype wire

/* testbench/tb_commit_rename.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_commit_rename;
    import rename_pkg::*;

    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 40;
    localparam int ROB_SIZE  = 8;

    typedef enum logic [2:0] {OP_IDLE, OP_ALLOC, OP_WB, OP_COMMIT, OP_FLUSH} op_e;

    typedef struct packed {
        op_e        op;
        logic       uses;  // Bundle writes rd
        logic [4:0] rd;
        logic [4:0] rs1;   // Lookup ports, checked every row
        logic [4:0] rs2;
        logic [2:0] idx;   // Writeback or flush index
    } op_t;

    typedef struct packed {
        logic [2:0] idx;
        logic [4:0] rd;
        logic       uses;
        logic [6:0] pd_new;
        logic [6:0] pd_old;
        logic       done;
    } model_entry_t;

    logic                   clk;
    logic                   i_rst_n;
    logic                   i_alloc_valid;
    logic                   o_alloc_ready;
    decoded_bundle_t        i_alloc_bundle;
    logic [2:0]             o_alloc_rob_idx;
    logic [ARCH_W-1:0]      i_rs1_arch;
    logic [ARCH_W-1:0]      i_rs2_arch;
    logic [5:0]             o_rs1_phys;
    logic [5:0]             o_rs2_phys;
    logic                   i_wb_valid;
    fu_wb_t                 i_wb_pkt;
    logic                   o_commit_valid;
    logic                   i_commit_ready;
    rob_entry_t             o_commit_entry;
    logic [2:0]             o_commit_rob_idx;
    logic                   i_flush_valid;
    logic [2:0]             i_flush_rob_idx;
    logic                   o_recover_valid;
    logic [2:0]             o_recover_rob_idx;
    rob_entry_t             o_recover_entry;

    op_t          ops[$];       // Operation table
    int           fl_q[$];      // Model free list, head first
    int           rat[ARCH_REGS];
    model_entry_t rob_q[$];     // Model ROB, oldest first
    int           tail_m;
    int           walk_left;    // Recovery cycles still due
    int           seed;
    logic         table_ready;

    commit_rename #(
        .ARCH_REGS (ARCH_REGS),
        .PHYS_REGS (PHYS_REGS),
        .ROB_SIZE  (ROB_SIZE)
    ) i_commit_rename (.*);

    always #10 clk = ~clk;  // 20 ns period

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic add_op(input op_e op, input int uses, rd, rs1, rs2, idx);
        op_t row;
        row = '{op: op, uses: uses[0], rd: rd[4:0], rs1: rs1[4:0], rs2: rs2[4:0], idx: idx[2:0]};
        ops.push_back(row);
    endtask

    // Compare the cycle's outputs, then advance the model to the next edge
    task automatic predict_and_check(input op_t op);
        model_entry_t e;
        int           ready_exp;
        int           cv_exp;
        ready_exp = rob_q.size() < ROB_SIZE && fl_q.size() > 0 && walk_left == 0
                    && op.op != OP_FLUSH;
        cv_exp    = rob_q.size() > 0 && walk_left == 0;
        if (cv_exp) cv_exp = rob_q[0].done;
        check_value("o_rs1_phys", o_rs1_phys, rat[op.rs1]);  // Pre-rename view
        check_value("o_rs2_phys", o_rs2_phys, rat[op.rs2]);
        check_value("o_alloc_ready", o_alloc_ready, ready_exp);
        check_value("o_commit_valid", o_commit_valid, cv_exp);
        check_value("o_recover_valid", o_recover_valid, walk_left > 0);
        if (cv_exp) begin
            check_value("o_commit_rob_idx", o_commit_rob_idx, rob_q[0].idx);
            check_value("o_commit_entry.rd_arch", o_commit_entry.rd_arch, rob_q[0].rd);
            check_value("o_commit_entry.uses_rd", o_commit_entry.uses_rd, rob_q[0].uses);
            check_value("o_commit_entry.pd_new", o_commit_entry.pd_new, rob_q[0].pd_new);
            check_value("o_commit_entry.pd_old", o_commit_entry.pd_old, rob_q[0].pd_old);
        end
        if (walk_left > 0) begin
            e = rob_q.pop_back();  // Youngest first
            check_value("o_recover_rob_idx", o_recover_rob_idx, e.idx);
            check_value("o_recover_entry.rd_arch", o_recover_entry.rd_arch, e.rd);
            check_value("o_recover_entry.uses_rd", o_recover_entry.uses_rd, e.uses);
            check_value("o_recover_entry.pd_new", o_recover_entry.pd_new, e.pd_new);
            check_value("o_recover_entry.pd_old", o_recover_entry.pd_old, e.pd_old);
            if (e.uses) begin
                if (e.rd != 0) rat[e.rd] = e.pd_old;  // Restore
                fl_q.push_back(e.pd_new);
            end
            tail_m = e.idx;
            walk_left--;
        end
        if (op.op == OP_ALLOC && ready_exp) begin
            check_value("o_alloc_rob_idx", o_alloc_rob_idx, tail_m);
            e = '{idx: tail_m[2:0], rd: op.rd, uses: op.uses, pd_new: '0, pd_old: '0, done: 1'b0};
            if (op.uses) begin
                e.pd_new = fl_q.pop_front();
                e.pd_old = rat[op.rd];
                if (op.rd != 0) rat[op.rd] = e.pd_new;
            end
            rob_q.push_back(e);
            tail_m = (tail_m + 1) % ROB_SIZE;
        end
        if (op.op == OP_WB) begin
            foreach (rob_q[j]) begin
                if (rob_q[j].idx == op.idx) rob_q[j].done = 1'b1;
            end
        end
        if (op.op == OP_COMMIT && cv_exp) begin
            e = rob_q.pop_front();
            if (e.uses) fl_q.push_back(e.pd_old);  // Replaced mapping is free
        end
        if (op.op == OP_FLUSH && walk_left == 0) begin
            foreach (rob_q[j]) begin
                if (rob_q[j].idx == op.idx) walk_left = rob_q.size() - 1 - j;  // Younger only
            end
        end
    endtask

    initial begin
        wait (table_ready);
        repeat ((ops.size() + 4) * 20) @(posedge clk);
        $display("Timeout: the operation table did not finish in time");
        $display("Test FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        clk = 1'b0;
        i_rst_n = 1'b0;
        i_alloc_valid = 1'b0;
        i_alloc_bundle = '0;
        i_rs1_arch = '0;
        i_rs2_arch = '0;
        i_wb_valid = 1'b0;
        i_wb_pkt = '0;
        i_commit_ready = 1'b0;
        i_flush_valid = 1'b0;
        i_flush_rob_idx = '0;
        seed = 48730;
        table_ready = 1'b0;
        tail_m = 0;
        walk_left = 0;
        for (int i = 0; i < ARCH_REGS; i++) rat[i] = i;  // Identity after reset
        for (int i = ARCH_REGS; i < PHYS_REGS; i++) fl_q.push_back(i);

        add_op(OP_IDLE, 0, 0, 5, 7, 0);
        add_op(OP_ALLOC, 1, 3, 3, 4, 0);   // Takes 32
        add_op(OP_ALLOC, 0, 4, 3, 4, 0);   // No rd, no register
        add_op(OP_ALLOC, 1, 3, 3, 4, 0);   // Takes 33, old 32
        add_op(OP_IDLE, 0, 0, 3, 4, 0);
        add_op(OP_WB, 0, 0, 0, 0, 2);      // Out of order
        add_op(OP_WB, 0, 0, 0, 0, 1);
        add_op(OP_IDLE, 0, 0, 1, 2, 0);    // Head not done yet
        add_op(OP_WB, 0, 0, 0, 0, 0);
        repeat (2) add_op(OP_IDLE, 0, 0, 3, 4, 0);  // Commit held back
        repeat (3) add_op(OP_COMMIT, 0, 0, 3, 4, 0);
        for (int r = 1; r <= 8; r++) add_op(OP_ALLOC, 1, r + 4, r, r + 4, 0);
        add_op(OP_ALLOC, 1, 13, 5, 6, 0);  // Free list empty
        add_op(OP_WB, 0, 0, 0, 0, 3);
        add_op(OP_COMMIT, 0, 0, 5, 6, 0);  // Frees register 5
        add_op(OP_ALLOC, 1, 13, 5, 13, 0);
        add_op(OP_IDLE, 0, 0, 13, 5, 0);
        add_op(OP_FLUSH, 0, 0, 9, 10, 6);  // Five younger entries
        for (int r = 0; r < 6; r++) add_op(OP_IDLE, 0, 0, r + 8, r + 9, 0);
        add_op(OP_ALLOC, 1, 20, 9, 13, 0); // Reuses pushed registers
        add_op(OP_ALLOC, 1, 21, 20, 13, 0);
        add_op(OP_IDLE, 0, 0, 20, 21, 0);
        for (int r = 0; r < 24; r++) begin
            add_op((r % 3 == 2) ? OP_COMMIT : OP_WB, 0, 0, r % 32, (r * 7) % 32,
                   {$random(seed)} % ROB_SIZE);
        end
        for (int r = 0; r < ROB_SIZE; r++) add_op(OP_WB, 0, 0, r, r + 1, r);
        repeat (ROB_SIZE) add_op(OP_COMMIT, 0, 0, 20, 21, 0);  // Drain
        for (int r = 0; r < ROB_SIZE; r++) add_op(OP_ALLOC, 0, r, r, 20, 0);
        add_op(OP_ALLOC, 0, 1, 1, 2, 0);   // ROB full
        for (int r = 0; r < ROB_SIZE; r++) add_op(OP_WB, 0, 0, r, 21, r);
        add_op(OP_COMMIT, 0, 0, 3, 4, 0);
        add_op(OP_ALLOC, 0, 2, 3, 4, 0);   // Room again
        add_op(OP_IDLE, 0, 0, 13, 20, 0);
        table_ready = 1'b1;

        repeat (4) @(posedge clk);
        i_rst_n <= 1'b1;
        foreach (ops[n]) begin
            @(posedge clk);
            i_alloc_valid          <= (ops[n].op == OP_ALLOC);
            i_alloc_bundle.rd_arch <= ops[n].rd;
            i_alloc_bundle.uses_rd <= ops[n].uses;
            i_rs1_arch             <= ops[n].rs1;
            i_rs2_arch             <= ops[n].rs2;
            i_wb_valid             <= (ops[n].op == OP_WB);
            i_wb_pkt.rob_idx       <= ROB_W_MAX'(ops[n].idx);
            i_commit_ready         <= (ops[n].op == OP_COMMIT);
            i_flush_valid          <= (ops[n].op == OP_FLUSH);
            i_flush_rob_idx        <= ops[n].idx;
            @(negedge clk);  // Outputs settled mid-cycle
            predict_and_check(ops[n]);
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
source/rename_pkg.sv
source/free_list.sv
source/rename_table.sv
source/rob_slot.sv
source/rob_ctrl.sv
source/commit_rename.sv
testbench/tb_commit_rename.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_commit_rename
RTL_TOP   ?= commit_rename
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
RTL_SRCS  ?= source/rename_pkg.sv source/free_list.sv source/rename_table.sv \
             source/rob_slot.sv source/rob_ctrl.sv source/commit_rename.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@! grep -q "Test FAILED" $(LOG) && grep -q "Test OK" $(LOG)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD) $(LOG)
